// ==== compile.f ====
hw/lsb_pkg.sv
hw/lsb_slot.sv
hw/lsb_ring_ctrl.sv
hw/lsb_head_issue.sv
hw/lsb_load_return.sv
hw/lsb_top.sv
verification/lsb_tb.sv

// ==== verification/lsb_tb.sv ====
// load/store buffer testbench
module lsb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int A_OP = 0;
    localparam int A_ROB = 1;       // arg is the in_rob_store_ok level
    localparam int A_LDOK = 2;      // arg is the in_load_req_ok level
    localparam int A_WAIT = 3;
    localparam int A_FLUSH = 4;
    localparam int A_FULL = 5;
    localparam int A_DRAIN = 6;
    localparam int A_STOK = 7;      // arg is the in_store_req_ok level

    typedef struct {
        int               act;
        int               arg;
        lsb_pkg::lsb_op_t op;
        int               alu_dly;  // alu result delay in cycles or 0
        lsb_pkg::data_t   alu_data;
        bit               wait_cdb; // allocate while the qk result is on the cdb
        bit               drop;     // flushed before it issues
        bit               no_cdb;   // issued but its result flushed
    } row_t;

    typedef struct {
        bit                  st;
        lsb_pkg::store_req_t s;
        lsb_pkg::load_req_t  l;
    } exp_req_t;

    logic                in_clk = 1'b0;
    logic                in_rst, in_rdy, in_flush, in_alloc, full;
    logic                in_rob_store_ok, store_done, in_load_req_ok, in_load_data_valid;
    logic                in_store_req_ok;
    lsb_pkg::lsb_op_t    in_alloc_op;
    lsb_pkg::bcast_t     in_alu_bcast, cdb;
    lsb_pkg::load_req_t  load_req;
    lsb_pkg::store_req_t store_req;
    lsb_pkg::data_t      in_load_data;

    row_t            tbl[$];
    exp_req_t        exp_q[$];
    lsb_pkg::bcast_t cdb_q[$];
    lsb_pkg::data_t  res_by_tag[16];
    logic [31:0]     rng = 32'd85333;
    bit              tbl_ready = 0;
    bit              full_watch = 0;
    bit              rob_prev, ld_prev, st_prev;
    int              err_value = 0, err_proto = 0;
    int              st_req_cnt = 0, done_cnt = 0;
    int              resp_cnt = 0, alu_cnt = 0;
    lsb_pkg::data_t  resp_addr, alu_data;
    lsb_pkg::rob_tag_t alu_tag;

    lsb_top #(.LSB_DEPTH(8)) lsb_top_inst (
        .in_clk (in_clk), .in_rst (in_rst), .in_rdy (in_rdy), .in_flush (in_flush),
        .in_alloc (in_alloc), .in_alloc_op (in_alloc_op), .full (full),
        .in_alu_bcast (in_alu_bcast), .in_rob_store_ok (in_rob_store_ok),
        .store_done (store_done), .load_req (load_req), .in_load_req_ok (in_load_req_ok),
        .in_load_data_valid (in_load_data_valid), .in_load_data (in_load_data),
        .store_req (store_req), .in_store_req_ok (in_store_req_ok), .cdb (cdb)
    );

    always #20 in_clk = ~in_clk;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory contents hashed from the full address
    function automatic lsb_pkg::data_t mem_word(lsb_pkg::data_t addr);
        return lcg_next(lcg_next(addr ^ 32'h0001_4d55));
    endfunction

    function automatic lsb_pkg::rw_style_e exp_style(lsb_pkg::mem_op_e op);
        if (op == lsb_pkg::LB || op == lsb_pkg::LBU || op == lsb_pkg::SB)
            return lsb_pkg::RW_BYTE;
        if (op == lsb_pkg::LH || op == lsb_pkg::LHU || op == lsb_pkg::SH)
            return lsb_pkg::RW_HALF;
        return lsb_pkg::RW_WORD;
    endfunction

    function automatic lsb_pkg::data_t extend(lsb_pkg::data_t w, lsb_pkg::mem_op_e op);
        lsb_pkg::data_t b;
        lsb_pkg::data_t h;
        b = w & 32'h0000_00ff;
        h = w & 32'h0000_ffff;
        case (op)
            lsb_pkg::LB:  return w[7] ? (b | 32'hffff_ff00) : b;
            lsb_pkg::LH:  return w[15] ? (h | 32'hffff_0000) : h;
            lsb_pkg::LBU: return b;
            lsb_pkg::LHU: return h;
            default:      return w;
        endcase
    endfunction

    task automatic check_store(input lsb_pkg::store_req_t got, input lsb_pkg::store_req_t exp);
        if (got.addr !== exp.addr || got.style !== exp.style || got.value !== exp.value) begin
            $display("Fail store_req addr %h style %h value %h, expected %h %h %h",
                     got.addr, got.style, got.value, exp.addr, exp.style, exp.value);
            err_value++;
        end
    endtask

    task automatic check_load_req(input lsb_pkg::load_req_t got, input lsb_pkg::load_req_t exp);
        if (got.addr !== exp.addr || got.style !== exp.style) begin
            $display("Fail load_req addr %h style %h, expected %h %h",
                     got.addr, got.style, exp.addr, exp.style);
            err_value++;
        end
    endtask

    task automatic check_cdb(input lsb_pkg::bcast_t got, input lsb_pkg::bcast_t exp);
        if (got.tag !== exp.tag || got.data !== exp.data) begin
            $display("Fail cdb tag %h data %h, expected %h %h",
                     got.tag, got.data, exp.tag, exp.data);
            err_value++;
        end
    endtask

    // sample outputs at the falling edge and drive the next strobes
    task automatic tick();
        rob_prev = in_rob_store_ok;
        ld_prev  = in_load_req_ok;
        st_prev  = in_store_req_ok;
        @(negedge in_clk);
        in_alloc           = 1'b0;
        in_flush           = 1'b0;
        in_alu_bcast       = '0;
        in_load_data_valid = 1'b0;
        if (resp_cnt > 0) begin
            resp_cnt--;
            if (resp_cnt == 0) begin
                in_load_data_valid = 1'b1;
                in_load_data       = mem_word(resp_addr);
            end
        end
        if (alu_cnt > 0) begin
            alu_cnt--;
            if (alu_cnt == 0) begin
                in_alu_bcast.valid = 1'b1;
                in_alu_bcast.tag   = alu_tag;
                in_alu_bcast.data  = alu_data;
            end
        end
        if (store_req.valid) begin
            if (!rob_prev || !st_prev) begin
                $display("store request sent while stores were held back");
                err_proto++;
            end
            if (exp_q.size() == 0 || !exp_q[0].st) begin
                $display("unexpected store request at %h", store_req.addr);
                err_proto++;
            end else begin
                check_store(store_req, exp_q[0].s);
                void'(exp_q.pop_front());
            end
            st_req_cnt++;
        end
        if (load_req.valid) begin
            if (!ld_prev) begin
                $display("load request sent while loads were held back");
                err_proto++;
            end
            if (exp_q.size() == 0 || exp_q[0].st) begin
                $display("unexpected load request at %h", load_req.addr);
                err_proto++;
            end else begin
                check_load_req(load_req, exp_q[0].l);
                void'(exp_q.pop_front());
            end
            rng       = lcg_next(rng);
            resp_cnt  = 1 + int'(rng[17:16]);   // 1 to 4 cycles
            resp_addr = load_req.addr;
        end
        if (store_done) begin
            if (done_cnt >= st_req_cnt) begin
                $display("store done pulse without an outstanding store");
                err_proto++;
            end
            if (full_watch && full) begin
                $display("full still high after the first pop");
                err_proto++;
            end
            full_watch = 0;
            done_cnt++;
        end
        if (cdb.valid) begin
            if (cdb_q.size() == 0) begin
                $display("unexpected cdb broadcast for tag %h", cdb.tag);
                err_proto++;
            end else begin
                check_cdb(cdb, cdb_q.pop_front());
            end
        end
    endtask

    function automatic lsb_pkg::data_t src_val(lsb_pkg::rob_tag_t tag, lsb_pkg::data_t v,
                                               row_t r);
        if (tag == '0)
            return v;
        return (r.alu_dly > 0) ? r.alu_data : res_by_tag[tag];
    endfunction

    task automatic apply_op(input row_t r);
        lsb_pkg::data_t  addr, res, vk_eff;
        exp_req_t        e;
        lsb_pkg::bcast_t c;
        if (r.wait_cdb) begin
            while (!(cdb.valid && cdb.tag == r.op.qk))
                tick();
        end
        while (full)
            tick();
        addr   = src_val(r.op.qj, r.op.vj, r) + r.op.imm;
        vk_eff = src_val(r.op.qk, r.op.vk, r);
        e      = '{st: 1'b0, s: '0, l: '0};
        if (r.op.op inside {lsb_pkg::SB, lsb_pkg::SH, lsb_pkg::SW}) begin
            e.st = 1'b1;
            e.s  = '{valid: 1'b1, addr: addr, style: exp_style(r.op.op), value: vk_eff};
        end else begin
            e.l = '{valid: 1'b1, addr: addr, style: exp_style(r.op.op)};
            res = extend(mem_word(addr), r.op.op);
            res_by_tag[r.op.dest] = res;
            c = '{valid: 1'b1, tag: r.op.dest, data: res};
            if (!r.drop && !r.no_cdb)
                cdb_q.push_back(c);
        end
        if (!r.drop)
            exp_q.push_back(e);
        in_alloc    = 1'b1;
        in_alloc_op = r.op;
        if (r.alu_dly > 0) begin
            alu_cnt  = r.alu_dly;
            alu_tag  = (r.op.qj != '0) ? r.op.qj : r.op.qk;
            alu_data = r.alu_data;
        end
        tick();
    endtask

    task automatic add_op(input lsb_pkg::mem_op_e op, input lsb_pkg::data_t imm,
                          input lsb_pkg::rob_tag_t qj, input lsb_pkg::rob_tag_t qk,
                          input lsb_pkg::data_t vj, input lsb_pkg::data_t vk,
                          input lsb_pkg::rob_tag_t dest, input int alu_dly,
                          input lsb_pkg::data_t alu_d, input bit wait_cdb,
                          input bit drop, input bit no_cdb);
        row_t r;
        r.act = A_OP;
        r.arg = 0;
        r.op  = '{op: op, imm: imm, qj: qj, qk: qk, vj: vj, vk: vk, dest: dest};
        r.alu_dly  = alu_dly;
        r.alu_data = alu_d;
        r.wait_cdb = wait_cdb;
        r.drop     = drop;
        r.no_cdb   = no_cdb;
        tbl.push_back(r);
    endtask

    task automatic add_ctl(input int act, input int arg);
        row_t r;
        r     = '{act: act, arg: arg, op: '0, alu_dly: 0, alu_data: '0,
                  wait_cdb: 0, drop: 0, no_cdb: 0};
        tbl.push_back(r);
    endtask

    task automatic build_table();
        add_op(lsb_pkg::SB, 32'h4, 0, 0, 32'h100, 32'h1122_33ab, 0, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::SH, 32'h22, 0, 0, 32'h200, 32'h5566_8001, 0, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::SW, 32'hffff_fffc, 0, 0, 32'h300, 32'hdead_beef, 0, 0, 0, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
        add_op(lsb_pkg::LB, 32'h1, 0, 0, 32'h400, 0, 1, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::LH, 32'h12, 0, 0, 32'h400, 0, 2, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::LW, 32'h8, 0, 0, 32'h480, 0, 3, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::LBU, 32'h7, 0, 0, 32'h500, 0, 4, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::LHU, 32'h2e, 0, 0, 32'h500, 0, 5, 0, 0, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
        // operands from a delayed alu result
        add_op(lsb_pkg::SW, 32'h10, 6, 0, 0, 32'h0bad_cafe, 0, 4, 32'h2000, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
        add_op(lsb_pkg::LW, 32'h20, 7, 0, 0, 0, 8, 3, 32'h3000, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
        // store value from an earlier load on the cdb
        add_op(lsb_pkg::LH, 32'h6, 0, 0, 32'h640, 0, 9, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::SW, 32'h0, 0, 9, 32'h700, 0, 0, 0, 0, 1, 0, 0);
        add_op(lsb_pkg::LW, 32'h4, 0, 0, 32'h740, 0, 10, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::SB, 32'h3, 0, 10, 32'h780, 0, 0, 0, 0, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
        // back-pressure
        add_ctl(A_ROB, 0);
        add_op(lsb_pkg::SW, 32'h8, 0, 0, 32'h800, 32'h1357_9bdf, 0, 0, 0, 0, 0, 0);
        add_ctl(A_WAIT, 6);
        add_ctl(A_ROB, 1);
        add_ctl(A_DRAIN, 0);
        add_ctl(A_LDOK, 0);
        add_op(lsb_pkg::LW, 32'hc, 0, 0, 32'h840, 0, 11, 0, 0, 0, 0, 0);
        add_ctl(A_WAIT, 6);
        add_ctl(A_LDOK, 1);
        add_ctl(A_DRAIN, 0);
        add_ctl(A_STOK, 0);
        add_op(lsb_pkg::SH, 32'h6, 0, 0, 32'h880, 32'h2468_ace0, 0, 0, 0, 0, 0, 0);
        add_ctl(A_WAIT, 6);
        add_ctl(A_STOK, 1);
        add_ctl(A_DRAIN, 0);
        // fill all eight slots
        add_ctl(A_ROB, 0);
        for (int i = 0; i < 8; i++)
            add_op(lsb_pkg::SW, 32'(i * 4), 0, 0, 32'h900, 32'(i) + 32'ha0, 0, 0, 0, 0, 0, 0);
        add_ctl(A_FULL, 0);
        add_ctl(A_ROB, 1);
        add_ctl(A_DRAIN, 0);
        // flush with a load outstanding
        add_ctl(A_ROB, 0);
        add_op(lsb_pkg::LW, 32'h0, 0, 0, 32'ha00, 0, 12, 0, 0, 0, 0, 1);
        add_op(lsb_pkg::SW, 32'h4, 0, 0, 32'ha40, 32'h7777_7777, 0, 0, 0, 0, 1, 0);
        add_op(lsb_pkg::LBU, 32'h9, 0, 0, 32'ha80, 0, 13, 0, 0, 0, 1, 0);
        add_ctl(A_FLUSH, 0);
        add_ctl(A_ROB, 1);
        add_op(lsb_pkg::LHU, 32'h16, 0, 0, 32'hb00, 0, 14, 0, 0, 0, 0, 0);
        add_op(lsb_pkg::SH, 32'h2, 0, 0, 32'hb40, 32'h0000_f00d, 0, 0, 0, 0, 0, 0);
        add_ctl(A_DRAIN, 0);
    endtask

    initial begin
        in_rst = 1'b1;
        in_rdy = 1'b1;
        in_flush = 1'b0;
        in_alloc = 1'b0;
        in_alloc_op = '0;
        in_alu_bcast = '0;
        in_rob_store_ok = 1'b1;
        in_store_req_ok = 1'b1;
        in_load_req_ok = 1'b1;
        in_load_data_valid = 1'b0;
        in_load_data = '0;
        build_table();
        tbl_ready = 1;
        repeat (16) @(negedge in_clk);
        in_rst = 1'b0;
        foreach (tbl[i]) begin
            case (tbl[i].act)
                A_OP:   apply_op(tbl[i]);
                A_ROB:  in_rob_store_ok = tbl[i].arg[0];
                A_LDOK: in_load_req_ok = tbl[i].arg[0];
                A_STOK: in_store_req_ok = tbl[i].arg[0];
                A_WAIT: repeat (tbl[i].arg) tick();
                A_FLUSH: begin
                    while (exp_q.size() != 0)
                        tick();
                    in_flush = 1'b1;
                    tick();
                end
                A_FULL: begin
                    if (!full) begin
                        $display("full not raised with all slots allocated");
                        err_proto++;
                    end
                    full_watch = 1;
                end
                default: begin
                    while (exp_q.size() != 0 || cdb_q.size() != 0 || resp_cnt != 0
                           || alu_cnt != 0 || done_cnt != st_req_cnt)
                        tick();
                    repeat (3) tick();
                end
            endcase
        end
        $display("errors: %0d value, %0d protocol", err_value, err_proto);
        if (err_value + err_proto == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (tbl_ready);
        #(tbl.size() * 60 * 40);
        $display("timeout, the test did not finish in time");
        $display("errors: %0d value, %0d protocol", err_value, err_proto);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hw/lsb_top.sv ====
// load/store buffer top
module lsb_top #(
    parameter int LSB_DEPTH = 16
) (
    input  logic                in_clk,
    input  logic                in_rst,
    input  logic                in_rdy,
    input  logic                in_flush,
    // decoder
    input  logic                in_alloc,
    input  lsb_pkg::lsb_op_t    in_alloc_op,
    output logic                full,
    // alu
    input  lsb_pkg::bcast_t     in_alu_bcast,
    // rob
    input  logic                in_rob_store_ok,
    output logic                store_done,
    // dispatcher
    output lsb_pkg::load_req_t  load_req,
    input  logic                in_load_req_ok,
    input  logic                in_load_data_valid,
    input  lsb_pkg::data_t      in_load_data,
    output lsb_pkg::store_req_t store_req,
    input  logic                in_store_req_ok,
    // common data bus
    output lsb_pkg::bcast_t     cdb
);
    logic [LSB_DEPTH-1:0]              alloc_sel;
    logic [LSB_DEPTH-1:0]              release_sel;
    logic [$clog2(LSB_DEPTH)-1:0]      head_idx;
    logic                              head_valid;
    logic                              pop;
    logic                              load_pending;
    lsb_pkg::lsb_op_t [LSB_DEPTH-1:0]  slot_ops;
    lsb_pkg::issued_load_t             issued_load;

    lsb_ring_ctrl #(
        .LSB_DEPTH (LSB_DEPTH)
    ) lsb_ring_ctrl_inst (
        .in_clk      (in_clk),
        .in_rst      (in_rst),
        .in_rdy      (in_rdy),
        .in_flush    (in_flush),
        .in_alloc    (in_alloc),
        .pop         (pop),
        .full        (full),
        .head_valid  (head_valid),
        .head_idx    (head_idx),
        .alloc_sel   (alloc_sel),
        .release_sel (release_sel)
    );

    for (genvar i = 0; i < LSB_DEPTH; i++) begin : g_slot
        lsb_slot lsb_slot_inst (
            .in_clk    (in_clk),
            .in_rst    (in_rst),
            .in_rdy    (in_rdy),
            .in_flush  (in_flush),
            .alloc     (alloc_sel[i]),
            .free      (release_sel[i]),
            .alloc_op  (in_alloc_op),
            .alu_bcast (in_alu_bcast),
            .cdb_bcast (cdb),
            .op        (slot_ops[i])
        );
    end

    lsb_head_issue #(
        .LSB_DEPTH (LSB_DEPTH)
    ) lsb_head_issue_inst (
        .in_clk          (in_clk),
        .in_rst          (in_rst),
        .in_rdy          (in_rdy),
        .in_flush        (in_flush),
        .slot_ops        (slot_ops),
        .head_idx        (head_idx),
        .head_valid      (head_valid),
        .in_rob_store_ok (in_rob_store_ok),
        .in_store_req_ok (in_store_req_ok),
        .in_load_req_ok  (in_load_req_ok),
        .load_pending    (load_pending),
        .pop             (pop),
        .store_done      (store_done),
        .store_req       (store_req),
        .load_req        (load_req),
        .issued_load     (issued_load)
    );

    lsb_load_return lsb_load_return_inst (
        .in_clk             (in_clk),
        .in_rst             (in_rst),
        .in_rdy             (in_rdy),
        .in_flush           (in_flush),
        .issued_load        (issued_load),
        .in_load_data_valid (in_load_data_valid),
        .in_load_data       (in_load_data),
        .load_pending       (load_pending),
        .cdb                (cdb)
    );

endmodule

// ==== hw/lsb_load_return.sv ====
// outstanding load record and cdb broadcast
module lsb_load_return (
    input  logic                  in_clk,
    input  logic                  in_rst,
    input  logic                  in_rdy,
    input  logic                  in_flush,
    input  lsb_pkg::issued_load_t issued_load,
    input  logic                  in_load_data_valid,
    input  lsb_pkg::data_t        in_load_data,
    output logic                  load_pending,
    output lsb_pkg::bcast_t       cdb
);
    lsb_pkg::rob_tag_t last_dest;
    lsb_pkg::mem_op_e  last_op;
    logic              killed;      // flushed, data still due from memory
    lsb_pkg::data_t    ext_data;

    always_comb begin
        case (last_op)
            lsb_pkg::LB:  ext_data = {{24{in_load_data[7]}}, in_load_data[7:0]};
            lsb_pkg::LH:  ext_data = {{16{in_load_data[15]}}, in_load_data[15:0]};
            lsb_pkg::LBU: ext_data = {24'd0, in_load_data[7:0]};
            lsb_pkg::LHU: ext_data = {16'd0, in_load_data[15:0]};
            default:      ext_data = in_load_data;
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            load_pending <= 1'b0;
            killed       <= 1'b0;
            cdb.valid    <= 1'b0;
        end else if (in_rdy) begin
            cdb.valid <= 1'b0;
            if (in_load_data_valid) begin
                load_pending <= 1'b0;
                killed       <= 1'b0;
                cdb.valid    <= !killed && !in_flush;
            end else if (in_flush) begin
                killed <= load_pending;
            end else if (issued_load.valid) begin
                load_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rdy && issued_load.valid) begin
            last_dest <= issued_load.dest;
            last_op   <= issued_load.op;
        end
        if (in_rdy && in_load_data_valid) begin
            cdb.tag  <= last_dest;
            cdb.data <= ext_data;
        end
    end

    a_data_pending : assert property (
        @(posedge in_clk) disable iff (in_rst)
        in_rdy && in_load_data_valid |-> load_pending
    );

endmodule

// ==== hw/lsb_head_issue.sv ====
// head entry issue for loads and stores
module lsb_head_issue #(
    parameter int LSB_DEPTH = 16
) (
    input  logic                                    in_clk,
    input  logic                                    in_rst,
    input  logic                                    in_rdy,
    input  logic                                    in_flush,
    input  lsb_pkg::lsb_op_t [LSB_DEPTH-1:0]        slot_ops,
    input  logic [$clog2(LSB_DEPTH)-1:0]            head_idx,
    input  logic                                    head_valid,
    input  logic                                    in_rob_store_ok,
    input  logic                                    in_store_req_ok,
    input  logic                                    in_load_req_ok,
    input  logic                                    load_pending,
    output logic                                    pop,
    output logic                                    store_done,
    output lsb_pkg::store_req_t                     store_req,
    output lsb_pkg::load_req_t                      load_req,
    output lsb_pkg::issued_load_t                   issued_load
);
    lsb_pkg::lsb_op_t  head_op;
    lsb_pkg::data_t    head_addr;
    lsb_pkg::rw_style_e head_style;
    logic              store_wait;  // store sent and waiting to retire
    logic              store_go;
    logic              load_go;

    assign head_op    = slot_ops[head_idx];
    assign head_addr  = head_op.vj + head_op.imm;
    assign head_style = lsb_pkg::style_of(head_op.op);

    assign store_go = head_valid
                   && lsb_pkg::is_store(head_op.op)
                   && head_op.qj == '0
                   && head_op.qk == '0
                   && in_rob_store_ok
                   && in_store_req_ok;

    // one load in flight at a time
    assign load_go = head_valid
                  && lsb_pkg::is_load(head_op.op)
                  && head_op.qj == '0
                  && in_load_req_ok
                  && !load_pending;

    // a store retires on its second eligible cycle and a load pops on issue
    assign pop = (store_go && store_wait) || load_go;

    always_comb begin
        issued_load.valid = load_go;
        issued_load.dest  = head_op.dest;
        issued_load.op    = head_op.op;
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            store_wait      <= 1'b0;
            store_done      <= 1'b0;
            store_req.valid <= 1'b0;
            load_req.valid  <= 1'b0;
        end else if (in_rdy) begin
            store_done      <= 1'b0;
            store_req.valid <= 1'b0;
            load_req.valid  <= 1'b0;
            if (in_flush) begin
                store_wait <= 1'b0;
            end else if (store_go) begin
                if (!store_wait) begin
                    store_wait      <= 1'b1;
                    store_req.valid <= 1'b1;
                end else begin
                    store_wait <= 1'b0;
                    store_done <= 1'b1;     // rob may commit now
                end
            end else if (load_go) begin
                load_req.valid <= 1'b1;
            end
        end
    end

    // request payloads
    always_ff @(posedge in_clk) begin
        if (in_rdy && store_go && !store_wait) begin
            store_req.addr  <= head_addr;
            store_req.style <= head_style;
            store_req.value <= head_op.vk;
        end
        if (in_rdy && load_go) begin
            load_req.addr  <= head_addr;
            load_req.style <= head_style;
        end
    end

    // sent store stays at the head until it retires
    a_store_wait_head : assert property (
        @(posedge in_clk) disable iff (in_rst)
        store_wait |-> head_valid && lsb_pkg::is_store(head_op.op)
    );

endmodule

// ==== hw/lsb_ring_ctrl.sv ====
// load/store ring pointers
module lsb_ring_ctrl #(
    parameter int LSB_DEPTH = 16
) (
    input  logic                         in_clk,
    input  logic                         in_rst,
    input  logic                         in_rdy,
    input  logic                         in_flush,
    input  logic                         in_alloc,
    input  logic                         pop,
    output logic                         full,
    output logic                         head_valid,
    output logic [$clog2(LSB_DEPTH)-1:0] head_idx,
    output logic [LSB_DEPTH-1:0]         alloc_sel,
    output logic [LSB_DEPTH-1:0]         release_sel
);
    localparam int IDX_W = $clog2(LSB_DEPTH);

    logic [IDX_W-1:0] head;
    logic [IDX_W-1:0] tail;
    logic [IDX_W:0]   count;

    assign full       = (count == (IDX_W + 1)'(LSB_DEPTH));
    assign head_valid = (count != '0);
    assign head_idx   = head;

    always_comb begin
        for (int i = 0; i < LSB_DEPTH; i++) begin
            alloc_sel[i]   = in_alloc && (tail == IDX_W'(i));
            release_sel[i] = pop && (head == IDX_W'(i));
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (in_rdy) begin
            if (in_flush) begin
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (in_alloc) begin
                    tail <= tail + 1'b1;    // wraps, depth is a power of two
                end
                if (pop) begin
                    head <= head + 1'b1;
                end
                case ({in_alloc, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // decoder has to hold off while the ring is full
    a_no_alloc_full : assert property (
        @(posedge in_clk) disable iff (in_rst)
        in_rdy && full |-> !in_alloc
    );

endmodule

// ==== hw/lsb_slot.sv ====
// load/store buffer slot with operand snoop
module lsb_slot (
    input  logic             in_clk,
    input  logic             in_rst,
    input  logic             in_rdy,
    input  logic             in_flush,
    input  logic             alloc,
    input  logic             free,
    input  lsb_pkg::lsb_op_t alloc_op,
    input  lsb_pkg::bcast_t  alu_bcast,
    input  lsb_pkg::bcast_t  cdb_bcast,
    output lsb_pkg::lsb_op_t op
);
    logic             busy;
    lsb_pkg::lsb_op_t op_nxt;

    // snoop on the incoming bundle when allocating, else on the stored one
    always_comb begin
        op_nxt = alloc ? alloc_op : op;
        if (alu_bcast.valid && op_nxt.qj != '0 && op_nxt.qj == alu_bcast.tag) begin
            op_nxt.qj = '0;
            op_nxt.vj = alu_bcast.data;
        end
        if (alu_bcast.valid && op_nxt.qk != '0 && op_nxt.qk == alu_bcast.tag) begin
            op_nxt.qk = '0;
            op_nxt.vk = alu_bcast.data;
        end
        if (cdb_bcast.valid && op_nxt.qj != '0 && op_nxt.qj == cdb_bcast.tag) begin
            op_nxt.qj = '0;
            op_nxt.vj = cdb_bcast.data;
        end
        if (cdb_bcast.valid && op_nxt.qk != '0 && op_nxt.qk == cdb_bcast.tag) begin
            op_nxt.qk = '0;
            op_nxt.vk = cdb_bcast.data;
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            busy <= 1'b0;
        end else if (in_rdy) begin
            if (in_flush) begin
                busy <= 1'b0;
            end else if (alloc) begin
                busy <= 1'b1;
            end else if (free) begin
                busy <= 1'b0;   // popped at head
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (in_rdy && (alloc || busy)) begin
            op <= op_nxt;
        end
    end

    // ring never reuses a live slot on the pop cycle
    a_alloc_free : assert property (
        @(posedge in_clk) disable iff (in_rst)
        busy |-> !(alloc && free)
    );

endmodule

// ==== hw/lsb_pkg.sv ====
// load/store buffer shared types
package lsb_pkg;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  rob_tag_t;   // zero means no dependency

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        RW_BYTE = 2'd0,
        RW_HALF = 2'd1,
        RW_WORD = 2'd2
    } rw_style_e;

    // decoder bundle, 112 bits
    typedef struct packed {
        mem_op_e  op;
        data_t    imm;
        rob_tag_t qj;
        rob_tag_t qk;
        data_t    vj;   // base
        data_t    vk;   // store value
        rob_tag_t dest;
    } lsb_op_t;

    // result broadcast, alu and cdb
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    data;
    } bcast_t;

    typedef struct packed {
        logic      valid;
        data_t     addr;
        rw_style_e style;
    } load_req_t;

    typedef struct packed {
        logic      valid;
        data_t     addr;
        rw_style_e style;
        data_t     value;
    } store_req_t;

    // load handed from issue to return side
    typedef struct packed {
        logic     valid;
        rob_tag_t dest;
        mem_op_e  op;
    } issued_load_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic rw_style_e style_of(mem_op_e op);
        rw_style_e style;
        case (op)
            LB, LBU, SB: style = RW_BYTE;
            LH, LHU, SH: style = RW_HALF;
            default:     style = RW_WORD;
        endcase
        return style;
    endfunction

endpackage
